// File: sim/ioFwdTestdata.txt
// Columns: opcode arg1 arg2 arg3, all hex; f ends the list
// 1 load(addr,val) 2 irq(irq,fiq) 3 read(addr,exp) 4 back-to-back read(addr,exp)
// 5 write(addr,data) 6 drain(valid,addr,data) 7 status(irq,fiq,miss) 8 hready(exp)
7 00000000 00000000 00000000
1 00000100 11111111 00000000
1 00000104 22222222 00000000
1 00000108 33333333 00000000
1 0000010C 44444444 00000000
3 00000100 11111111 00000000
4 00000104 22222222 00000000
4 00000108 33333333 00000000
3 00000200 DEADBEEF 00000000 // not at the head
7 00000000 00000000 00000001
3 0000010C 44444444 00000000
2 00000001 00000001 00000000
7 00000001 00000001 00000001
2 00000001 00000000 00000000
7 00000001 00000000 00000001
2 00000000 00000000 00000000
7 00000000 00000000 00000001
6 00000000 00000000 00000000 // log still empty
5 00000400 A0A0A0A0 00000000
5 00000404 B1B1B1B1 00000000
5 00000408 C2C2C2C2 00000000
5 0000040C D3D3D3D3 00000000
5 00000410 E4E4E4E4 00000000 // log full, this one stalls
8 00000000 00000000 00000000
6 00000001 00000400 A0A0A0A0
8 00000001 00000000 00000000
6 00000001 00000404 B1B1B1B1
6 00000001 00000408 C2C2C2C2
6 00000001 0000040C D3D3D3D3
6 00000001 00000410 E4E4E4E4
6 00000000 00000000 00000000
f 00000000 00000000 00000000

// File: flist.f
source/ioFwdPkg.sv
source/ahbIoCtrl.sv
source/readReplayQueue.sv
source/hostLoadPort.sv
source/writeLog.sv
source/ioFwdTop.sv
sim/ioFwdTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ioFwdTb
FLIST     ?= flist.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

SOURCES := $(shell grep -v '^+' $(FLIST))

.PHONY: all build run lint clean

all: run

build: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: build
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "No pass result in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: sim/ioFwdTb.sv
// Testbench for the IO forwarding slave, replaying a command list read from the test data file
module ioFwdTb;
    import ioFwdPkg::*;

    localparam int maxCmds = 64;

    logic                 HCLK;
    logic                 arstN;
    logic                 HSEL;
    logic                 HREQUEST;
    logic [addrWidth-1:0] HADDR;
    logic                 HWRITE;
    logic [dataWidth-1:0] HWDATA;
    logic [dataWidth-1:0] HRDATA;
    logic                 HREADY;
    logic                 loadReq;
    loadOp                hostOp;
    logic [addrWidth-1:0] loadAddr;
    logic [dataWidth-1:0] loadData;
    logic                 loadAck;
    logic                 drainReq;
    logic                 drainAck;
    logic [addrWidth-1:0] drainAddr;
    logic [dataWidth-1:0] drainData;
    logic                 drainValid;
    logic                 irq;
    logic                 fiq;
    logic                 readMiss;

    // Four words per command: opcode, then three operands
    logic [31:0] testMem [0:4*maxCmds-1];
    int          numCmds;
    int          cycleCount;
    int          cycleLimit;
    integer      seed;
    int          idx;
    logic [31:0] op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    string       name;

    ioFwdTop DUT (.*, .loadOp(hostOp));

    initial HCLK = 1'b0;
    always #50 HCLK = ~HCLK;

    task automatic abortRun(input string reason);
        $display("Error: %s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "Run aborted");
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", testName, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    task automatic idleGap();
        int gap;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(negedge HCLK);
    endtask

    // Master holds the next address phase while a write is stalled
    task automatic waitBusReady();
        while (HREADY !== 1'b1) @(negedge HCLK);
    endtask

    task automatic busRead(input logic [31:0] addr, input logic [31:0] expected,
                           input string testName);
        waitBusReady();
        HSEL     = 1'b1;
        HREQUEST = 1'b1;
        HWRITE   = 1'b0;
        HADDR    = addr;
        @(negedge HCLK);
        HSEL     = 1'b0;
        HREQUEST = 1'b0;
        // Now in the data phase, where HRDATA is valid
        checkValue(testName, expected, HRDATA);
    endtask

    task automatic busWrite(input logic [31:0] addr, input logic [31:0] data);
        waitBusReady();
        HSEL     = 1'b1;
        HREQUEST = 1'b1;
        HWRITE   = 1'b1;
        HADDR    = addr;
        @(negedge HCLK);
        HSEL     = 1'b0;
        HREQUEST = 1'b0;
        HWRITE   = 1'b0;
        // Held here until a later write replaces it
        HWDATA   = data;
    endtask

    task automatic hostLoad(input loadOp cmd, input logic [31:0] addr,
                            input logic [31:0] data, input string testName);
        hostOp   = cmd;
        loadAddr = addr;
        loadData = data;
        loadReq  = 1'b1;
        while (loadAck !== 1'b1) @(negedge HCLK);
        @(negedge HCLK);
        checkValue({testName, " loadAck held"}, 32'h1, {31'b0, loadAck});
        loadReq = 1'b0;
        while (loadAck !== 1'b0) @(negedge HCLK);
    endtask

    task automatic drainOne(input logic [31:0] expValid, input logic [31:0] expAddr,
                            input logic [31:0] expData, input string testName);
        drainReq = 1'b1;
        while (drainAck !== 1'b1) @(negedge HCLK);
        checkValue({testName, " valid"}, expValid, {31'b0, drainValid});
        if (expValid[0]) begin
            checkValue({testName, " addr"}, expAddr, drainAddr);
            checkValue({testName, " data"}, expData, drainData);
        end
        @(negedge HCLK);
        checkValue({testName, " drainAck held"}, 32'h1, {31'b0, drainAck});
        drainReq = 1'b0;
        while (drainAck !== 1'b0) @(negedge HCLK);
    endtask

    task automatic checkStatus(input logic [31:0] expIrq, input logic [31:0] expFiq,
                               input logic [31:0] expMiss, input string testName);
        checkValue({testName, " irq"}, expIrq, {31'b0, irq});
        checkValue({testName, " fiq"}, expFiq, {31'b0, fiq});
        checkValue({testName, " readMiss"}, expMiss, {31'b0, readMiss});
    endtask

    // Cycle budget scales with the number of commands
    always @(posedge HCLK) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            abortRun($sformatf("timed out after %0d cycles before all commands finished",
                               cycleCount));
        end
    end

    initial begin
        arstN      = 1'b0;
        HSEL       = 1'b0;
        HREQUEST   = 1'b0;
        HADDR      = '0;
        HWRITE     = 1'b0;
        HWDATA     = '0;
        loadReq    = 1'b0;
        hostOp     = loadPushRead;
        loadAddr   = '0;
        loadData   = '0;
        drainReq   = 1'b0;
        seed       = 32'h4c1a2dac;
        cycleCount = 0;
        cycleLimit = maxCmds * 20 + 50;

        $readmemh("sim/ioFwdTestdata.txt", testMem);
        numCmds = 0;
        while (numCmds < maxCmds && testMem[4*numCmds] !== 32'hF) begin
            numCmds++;
        end
        if (numCmds == maxCmds) begin
            abortRun("test data file is missing or has no end marker");
        end
        cycleLimit = numCmds * 20 + 50;

        repeat (4) @(negedge HCLK);
        arstN = 1'b1;

        for (idx = 0; idx < numCmds; idx++) begin
            op   = testMem[4*idx];
            a    = testMem[4*idx+1];
            b    = testMem[4*idx+2];
            c    = testMem[4*idx+3];
            name = $sformatf("cmd %0d op %0h arg %h", idx, op, a);
            // Opcode 4 is a read that follows the previous one with no gap
            if (op != 32'h4) begin
                idleGap();
            end
            case (op)
                32'h1: hostLoad(loadPushRead, a, b, name);
                32'h2: hostLoad(loadSetIrq, 32'h0, {30'b0, b[0], a[0]}, name);
                32'h3, 32'h4: busRead(a, b, name);
                32'h5: busWrite(a, b);
                32'h6: drainOne(a, b, c, name);
                32'h7: checkStatus(a, b, c, name);
                32'h8: checkValue(name, a, {31'b0, HREADY});
                default: abortRun($sformatf("unknown opcode %h in command %0d", op, idx));
            endcase
        end

        $display("Ran %0d commands", numCmds);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: source/ioFwdTop.sv
// IO forwarding slave top level joining the AHB control, replay queue, load port and write log
module ioFwdTop (
    input  logic                            HCLK,
    input  logic                            arstN,
    input  logic                            HSEL,
    input  logic                            HREQUEST,
    input  logic [ioFwdPkg::addrWidth-1:0]  HADDR,
    input  logic                            HWRITE,
    input  logic [ioFwdPkg::dataWidth-1:0]  HWDATA,
    output logic [ioFwdPkg::dataWidth-1:0]  HRDATA,
    output logic                            HREADY,
    input  logic                            loadReq,
    input  ioFwdPkg::loadOp                 loadOp,
    input  logic [ioFwdPkg::addrWidth-1:0]  loadAddr,
    input  logic [ioFwdPkg::dataWidth-1:0]  loadData,
    output logic                            loadAck,
    input  logic                            drainReq,
    output logic                            drainAck,
    output logic [ioFwdPkg::addrWidth-1:0]  drainAddr,
    output logic [ioFwdPkg::dataWidth-1:0]  drainData,
    output logic                            drainValid,
    output logic                            irq,
    output logic                            fiq,
    output logic                            readMiss
);
    import ioFwdPkg::*;

    logic [addrWidth-1:0] phaseAddr;
    logic                 readPhase;
    logic                 popHit;
    logic                 logPush;
    logic                 headHit;
    logic                 queueFull;
    logic                 logFull;
    logic                 pushEn;
    logic [addrWidth-1:0] pushAddr;
    logic [dataWidth-1:0] pushData;

    ahbIoCtrl ctrl (
        .HCLK, .arstN, .HSEL, .HREQUEST, .HWRITE, .HADDR, .headHit, .logFull,
        .HREADY, .phaseAddr, .readPhase, .popHit, .logPush, .readMiss
    );

    readReplayQueue replay (
        .HCLK, .arstN, .pushEn, .pushAddr, .pushData, .popHit, .phaseAddr,
        .readPhase, .headHit, .queueFull, .queueEmpty(), .HRDATA
    );

    hostLoadPort loadPort (
        .HCLK, .arstN, .loadReq, .loadOp, .loadAddr, .loadData, .queueFull,
        .loadAck, .pushEn, .pushAddr, .pushData, .irq, .fiq
    );

    writeLog wrLog (
        .HCLK, .arstN, .logPush, .phaseAddr, .HWDATA, .drainReq,
        .logFull, .drainAck, .drainAddr, .drainData, .drainValid
    );

endmodule

// File: source/writeLog.sv
// Write log FIFO of captured AHB writes, drained by the host over a four-phase port
module writeLog (
    input  logic                            HCLK,
    input  logic                            arstN,
    input  logic                            logPush,
    input  logic [ioFwdPkg::addrWidth-1:0]  phaseAddr,
    input  logic [ioFwdPkg::dataWidth-1:0]  HWDATA,
    input  logic                            drainReq,
    output logic                            logFull,
    output logic                            drainAck,
    output logic [ioFwdPkg::addrWidth-1:0]  drainAddr,
    output logic [ioFwdPkg::dataWidth-1:0]  drainData,
    output logic                            drainValid
);
    import ioFwdPkg::*;

    logic [addrWidth-1:0]  addrMem [logDepth];
    logic [dataWidth-1:0]  dataMem [logDepth];
    logic [logPtrWidth:0]  wrPtr;
    logic [logPtrWidth:0]  rdPtr;
    logic                  logEmpty;
    logic                  reqSync;
    logic                  fire;

    assign logEmpty = (wrPtr == rdPtr);
    assign logFull  = (wrPtr[logPtrWidth] != rdPtr[logPtrWidth]) &&
                      (wrPtr[logPtrWidth-1:0] == rdPtr[logPtrWidth-1:0]);

    // One pop per request, even when the log is empty
    assign fire = reqSync && !drainAck;

    always_ff @(posedge HCLK) begin
        if (logPush) begin
            addrMem[wrPtr[logPtrWidth-1:0]] <= phaseAddr;
            dataMem[wrPtr[logPtrWidth-1:0]] <= HWDATA;
        end
        if (fire && !logEmpty) begin
            drainAddr <= addrMem[rdPtr[logPtrWidth-1:0]];
            drainData <= dataMem[rdPtr[logPtrWidth-1:0]];
        end
    end

    always_ff @(posedge HCLK or negedge arstN) begin
        if (!arstN) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            reqSync    <= 1'b0;
            drainAck   <= 1'b0;
            drainValid <= 1'b0;
        end else begin
            reqSync <= drainReq;
            if (logPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (fire) begin
                drainAck   <= 1'b1;
                drainValid <= !logEmpty;
                if (!logEmpty) begin
                    rdPtr <= rdPtr + 1'b1;
                end
            end else if (!reqSync) begin
                drainAck <= 1'b0;
            end
        end
    end

endmodule

// File: source/hostLoadPort.sv
// Four-phase host load port that pushes read records or sets the interrupt lines
module hostLoadPort (
    input  logic                            HCLK,
    input  logic                            arstN,
    input  logic                            loadReq,
    input  ioFwdPkg::loadOp                 loadOp,
    input  logic [ioFwdPkg::addrWidth-1:0]  loadAddr,
    input  logic [ioFwdPkg::dataWidth-1:0]  loadData,
    input  logic                            queueFull,
    output logic                            loadAck,
    output logic                            pushEn,
    output logic [ioFwdPkg::addrWidth-1:0]  pushAddr,
    output logic [ioFwdPkg::dataWidth-1:0]  pushData,
    output logic                            irq,
    output logic                            fiq
);
    import ioFwdPkg::*;

    logic reqSync;
    logic blocked;
    logic fire;

    // A push has to wait for room in the queue
    assign blocked = (loadOp == loadPushRead) && queueFull;

    // New request is one that is high but not yet acknowledged
    assign fire = reqSync && !loadAck && !blocked;

    assign pushEn   = fire && (loadOp == loadPushRead);
    assign pushAddr = loadAddr;
    assign pushData = loadData;

    always_ff @(posedge HCLK or negedge arstN) begin
        if (!arstN) begin
            reqSync <= 1'b0;
            loadAck <= 1'b0;
            irq     <= 1'b0;
            fiq     <= 1'b0;
        end else begin
            reqSync <= loadReq;
            if (fire) begin
                loadAck <= 1'b1;
            end else if (!reqSync) begin
                // Return to zero once the host drops its request
                loadAck <= 1'b0;
            end
            if (fire && (loadOp == loadSetIrq)) begin
                irq <= loadData[0];
                fiq <= loadData[1];
            end
        end
    end

    // Never push into a full queue
    pushHasRoom: assert property (
        @(posedge HCLK) disable iff (!arstN)
        pushEn |-> !queueFull
    );

endmodule

// File: source/readReplayQueue.sv
// Replay queue of recorded IO reads, compared against the data-phase address
module readReplayQueue (
    input  logic                            HCLK,
    input  logic                            arstN,
    input  logic                            pushEn,
    input  logic [ioFwdPkg::addrWidth-1:0]  pushAddr,
    input  logic [ioFwdPkg::dataWidth-1:0]  pushData,
    input  logic                            popHit,
    input  logic [ioFwdPkg::addrWidth-1:0]  phaseAddr,
    input  logic                            readPhase,
    output logic                            headHit,
    output logic                            queueFull,
    output logic                            queueEmpty,
    output logic [ioFwdPkg::dataWidth-1:0]  HRDATA
);
    import ioFwdPkg::*;

    logic [addrWidth-1:0]    addrMem [replayDepth];
    logic [dataWidth-1:0]    dataMem [replayDepth];
    logic [replayPtrWidth:0] wrPtr;
    logic [replayPtrWidth:0] rdPtr;
    logic [addrWidth-1:0]    headAddr;
    logic [dataWidth-1:0]    headData;

    // Extra pointer bit tells full from empty
    assign queueEmpty = (wrPtr == rdPtr);
    assign queueFull  = (wrPtr[replayPtrWidth] != rdPtr[replayPtrWidth]) &&
                        (wrPtr[replayPtrWidth-1:0] == rdPtr[replayPtrWidth-1:0]);

    assign headAddr = addrMem[rdPtr[replayPtrWidth-1:0]];
    assign headData = dataMem[rdPtr[replayPtrWidth-1:0]];

    assign headHit = !queueEmpty && (headAddr == phaseAddr);

    // Recorded value on a matching read, garbage marker otherwise
    assign HRDATA = (readPhase && headHit) ? headData : invalidReadData;

    always_ff @(posedge HCLK) begin
        if (pushEn) begin
            addrMem[wrPtr[replayPtrWidth-1:0]] <= pushAddr;
            dataMem[wrPtr[replayPtrWidth-1:0]] <= pushData;
        end
    end

    always_ff @(posedge HCLK or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (pushEn) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (popHit) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    // Control must only pop a head that exists
    noPopWhenEmpty: assert property (
        @(posedge HCLK) disable iff (!arstN)
        popHit |-> !queueEmpty
    );

endmodule

// File: source/ahbIoCtrl.sv
// AHB-Lite control FSM that sequences address and data phases and issues pop and log strobes
module ahbIoCtrl (
    input  logic                            HCLK,
    input  logic                            arstN,
    input  logic                            HSEL,
    input  logic                            HREQUEST,
    input  logic                            HWRITE,
    input  logic [ioFwdPkg::addrWidth-1:0]  HADDR,
    input  logic                            headHit,
    input  logic                            logFull,
    output logic                            HREADY,
    output logic [ioFwdPkg::addrWidth-1:0]  phaseAddr,
    output logic                            readPhase,
    output logic                            popHit,
    output logic                            logPush,
    output logic                            readMiss
);
    import ioFwdPkg::*;

    busState state;
    busState nextState;
    logic    writePhase;
    logic    addrPhase;

    assign readPhase  = (state == busRead);
    assign writePhase = (state == busWrite) || (state == busWait);

    // Only a write stuck behind a full log stretches its data phase
    assign HREADY = !(writePhase && logFull);

    // Address phase is accepted on the same edge that ends the current data phase
    assign addrPhase = HSEL && HREQUEST && HREADY;

    assign popHit  = readPhase && headHit;
    assign logPush = writePhase && !logFull;

    always_comb begin
        if (!HREADY) begin
            nextState = busWait;
        end else if (addrPhase) begin
            nextState = HWRITE ? busWrite : busRead;
        end else begin
            nextState = busIdle;
        end
    end

    always_ff @(posedge HCLK or negedge arstN) begin
        if (!arstN) begin
            state <= busIdle;
        end else begin
            state <= nextState;
        end
    end

    // Data phase address, held through a stalled write
    always_ff @(posedge HCLK) begin
        if (addrPhase) begin
            phaseAddr <= HADDR;
        end
    end

    // Sticky until reset
    always_ff @(posedge HCLK or negedge arstN) begin
        if (!arstN) begin
            readMiss <= 1'b0;
        end else if (readPhase && !headHit) begin
            readMiss <= 1'b1;
        end
    end

    // A data phase is either a read or a write, never both
    noPopAndPush: assert property (
        @(posedge HCLK) disable iff (!arstN)
        !(popHit && logPush)
    );

    // Idle bus never stalls the master
    idleReady: assert property (
        @(posedge HCLK) disable iff (!arstN)
        (state == busIdle) |-> HREADY
    );

endmodule

// File: source/ioFwdPkg.sv
// IO forwarding package with bus widths, FIFO depths, the read-miss constant and shared enums
package ioFwdPkg;

    // AHB address and data widths
    localparam int addrWidth = 32;
    localparam int dataWidth = 32;

    // Recorded reads waiting to be replayed
    localparam int replayDepth = 8;
    localparam int replayPtrWidth = $clog2(replayDepth);

    // Small on purpose so that a full log is easy to reach
    localparam int logDepth = 4;
    localparam int logPtrWidth = $clog2(logDepth);

    // Returned on a read that does not match the queue head
    localparam logic [dataWidth-1:0] invalidReadData = 32'hDEAD_BEEF;

    // Control FSM of the AHB side
    typedef enum logic [1:0] {
        busIdle  = 2'd0,
        busRead  = 2'd1,
        busWrite = 2'd2,
        busWait  = 2'd3
    } busState;

    // Commands on the host load port
    typedef enum logic [1:0] {
        loadPushRead = 2'd0,
        loadSetIrq   = 2'd1
    } loadOp;

endpackage
